/* Bender.yml */
package:
  name: anc

sources:
  - files:
      - rtl/anc_pkg.sv
      - rtl/anc_sequencer.sv
      - rtl/anc_ref_delay_line.sv
      - rtl/anc_weight_bank.sv
      - rtl/anc_channel.sv
      - rtl/anc_top.sv
  - target: test
    files:
      - tests/anc_sva.sv
      - tests/anc_tb.sv

/* anc.f */
rtl/anc_pkg.sv
rtl/anc_sequencer.sv
rtl/anc_ref_delay_line.sv
rtl/anc_weight_bank.sv
rtl/anc_channel.sv
rtl/anc_top.sv
tests/anc_sva.sv
tests/anc_tb.sv

/* rtl/anc_channel.sv */
`timescale 1ns/1ps

module anc_channel
    import anc_pkg::*;
#(
    parameter int TAPS      = 8,
    parameter int FRAC_BITS = 16,
    parameter int MU_SHIFT  = 14
)
(
    input  logic                      clk,
    input  logic                      rstn,
    input  sample_t                   primary,
    input  phase_e                    phase,
    input  logic [$clog2(TAPS)-1:0]   tap,
    input  sample_t                   ref_tap,
    output sample_t                   err
);

    sample_t    primary_q;
    acc_t       acc;
    acc_t       product;
    sample_t    estimate;
    weight_t    rd_weight;
    weight_t    err_ref;
    weight_t    step;
    weight_t    new_weight;
    logic       wr_en;

    // weight times reference at full accumulator width
    assign product = acc_t'(rd_weight) * acc_t'(ref_tap);

    // drop the weight fraction and keep the low sample bits
    assign estimate = sample_t'(acc >>> FRAC_BITS);

    always_ff @(posedge clk)
    begin
        if (phase == PH_SHIFT)
        begin
            primary_q <= primary;
            acc       <= '0;
        end
        else if (phase == PH_FILTER)
        begin
            acc <= acc + product;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            err <= '0;
        else if (phase == PH_ERROR)
            err <= primary_q - estimate;
    end

    // lms step is err * ref scaled down by mu
    assign err_ref    = weight_t'(err) * weight_t'(ref_tap);
    assign step       = err_ref >>> MU_SHIFT;
    assign new_weight = rd_weight + step;
    assign wr_en      = (phase == PH_UPDATE);

    // read and write back the same tap each update cycle
    anc_weight_bank #(
        .TAPS (TAPS)
    ) i_weight_bank (
        .clk     (clk),
        .rstn    (rstn),
        .rd_addr (tap),
        .rd_data (rd_weight),
        .wr_en   (wr_en),
        .wr_addr (tap),
        .wr_data (new_weight)
    );

endmodule

/* rtl/anc_pkg.sv */
package anc_pkg;

    localparam int SAMPLE_W = 14;
    localparam int WEIGHT_W = 32;
    localparam int ACC_W    = 48;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // fixed point, FRAC_BITS set at the top level
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // one sample set per frame
    typedef struct packed {
        sample_t primary_a;
        sample_t primary_b;
        sample_t noise_ref;
    } frame_in_t;

    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_SHIFT  = 3'd1,
        PH_FILTER = 3'd2,
        PH_ERROR  = 3'd3,
        PH_UPDATE = 3'd4,
        PH_HOLD   = 3'd5
    } phase_e;

endpackage

/* rtl/anc_ref_delay_line.sv */
`timescale 1ns/1ps

module anc_ref_delay_line
    import anc_pkg::*;
#(
    parameter int TAPS = 8
)
(
    input  logic                      clk,
    input  logic                      rstn,
    input  sample_t                   noise_ref,
    input  phase_e                    phase,
    input  logic [$clog2(TAPS)-1:0]   tap,
    output sample_t                   ref_tap
);

    // index 0 holds the newest reference sample
    sample_t ref_q [TAPS];

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int k = 0; k < TAPS; k++)
                ref_q[k] <= '0;
        end
        else if (phase == PH_SHIFT)
        begin
            ref_q[0] <= noise_ref;
            for (int k = 1; k < TAPS; k++)
                ref_q[k] <= ref_q[k-1];
        end
    end

    // shared by the filter and update passes of both channels
    assign ref_tap = ref_q[tap];

endmodule

/* rtl/anc_sequencer.sv */
`timescale 1ns/1ps

module anc_sequencer
    import anc_pkg::*;
#(
    parameter int TAPS = 8
)
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      head_flag,
    output phase_e                    phase,
    output logic [$clog2(TAPS)-1:0]   tap,
    output logic                      frame_done
);

    localparam int TAP_W = $clog2(TAPS);

    logic last_tap;

    assign last_tap = (tap == TAP_W'(TAPS - 1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            phase      <= PH_IDLE;
            tap        <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            case (phase)
                PH_IDLE:
                begin
                    if (head_flag)
                        phase <= PH_SHIFT;
                end
                PH_SHIFT:
                begin
                    phase <= PH_FILTER;
                end
                // one tap per cycle
                PH_FILTER:
                begin
                    if (last_tap)
                    begin
                        tap   <= '0;
                        phase <= PH_ERROR;
                    end
                    else
                        tap <= tap + 1'b1;
                end
                PH_ERROR:
                begin
                    phase <= PH_UPDATE;
                end
                PH_UPDATE:
                begin
                    if (last_tap)
                    begin
                        tap        <= '0;
                        phase      <= PH_HOLD;
                        frame_done <= 1'b1;
                    end
                    else
                        tap <= tap + 1'b1;
                end
                // re-arm only once the flag drops
                PH_HOLD:
                begin
                    if (!head_flag)
                        phase <= PH_IDLE;
                end
                default:
                begin
                    phase <= PH_IDLE;
                    tap   <= '0;
                end
            endcase
        end
    end

endmodule

/* rtl/anc_top.sv */
`timescale 1ns/1ps

module anc_top
    import anc_pkg::*;
#(
    parameter int TAPS      = 8,
    parameter int FRAC_BITS = 16,
    parameter int MU_SHIFT  = 14
)
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        head_flag,
    input  frame_in_t   frame,
    output sample_t     dout,
    output logic        frame_done
);

    localparam int TAP_W = $clog2(TAPS);

    phase_e             phase;
    logic [TAP_W-1:0]   tap;
    sample_t            ref_tap;
    sample_t            err_a;
    sample_t            err_b;
    logic               load_dout;

    anc_sequencer #(
        .TAPS (TAPS)
    ) i_sequencer (
        .clk        (clk),
        .rstn       (rstn),
        .head_flag  (head_flag),
        .phase      (phase),
        .tap        (tap),
        .frame_done (frame_done)
    );

    anc_ref_delay_line #(
        .TAPS (TAPS)
    ) i_ref_delay_line (
        .clk       (clk),
        .rstn      (rstn),
        .noise_ref (frame.noise_ref),
        .phase     (phase),
        .tap       (tap),
        .ref_tap   (ref_tap)
    );

    anc_channel #(
        .TAPS      (TAPS),
        .FRAC_BITS (FRAC_BITS),
        .MU_SHIFT  (MU_SHIFT)
    ) i_channel_a (
        .clk     (clk),
        .rstn    (rstn),
        .primary (frame.primary_a),
        .phase   (phase),
        .tap     (tap),
        .ref_tap (ref_tap),
        .err     (err_a)
    );

    anc_channel #(
        .TAPS      (TAPS),
        .FRAC_BITS (FRAC_BITS),
        .MU_SHIFT  (MU_SHIFT)
    ) i_channel_b (
        .clk     (clk),
        .rstn    (rstn),
        .primary (frame.primary_b),
        .phase   (phase),
        .tap     (tap),
        .ref_tap (ref_tap),
        .err     (err_b)
    );

    // last update cycle, so dout lines up with frame_done
    assign load_dout = (phase == PH_UPDATE) && (tap == TAP_W'(TAPS - 1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            dout <= '0;
        else if (load_dout)
            dout <= err_a + err_b;
    end

endmodule

/* rtl/anc_weight_bank.sv */
`timescale 1ns/1ps

module anc_weight_bank
    import anc_pkg::*;
#(
    parameter int TAPS = 8
)
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [$clog2(TAPS)-1:0]   rd_addr,
    output weight_t                   rd_data,
    input  logic                      wr_en,
    input  logic [$clog2(TAPS)-1:0]   wr_addr,
    input  weight_t                   wr_data
);

    weight_t weight_q [TAPS];

    // weights start from zero after reset
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int k = 0; k < TAPS; k++)
                weight_q[k] <= '0;
        end
        else if (wr_en)
        begin
            weight_q[wr_addr] <= wr_data;
        end
    end

    // combinational read, same cycle
    assign rd_data = weight_q[rd_addr];

endmodule

/* tests/anc_sva.sv */
`timescale 1ns/1ps

module anc_sva
    import anc_pkg::*;
#(
    parameter int TAPS = 8
)
(
    input logic     clk,
    input logic     rstn,
    input logic     head_flag,
    input phase_e   phase,
    input logic     frame_done
);

    logic armed;

    // head_flag seen low since the last frame_done
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            armed <= 1'b1;
        else if (!head_flag)
            armed <= 1'b1;
        else if (frame_done)
            armed <= 1'b0;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
        frame_done |=> !frame_done)
        else $error("frame_done held for more than one cycle");

    done_latency: assert property (@(posedge clk) disable iff (!rstn)
        (phase == PH_IDLE && head_flag) |-> ##(2 * TAPS + 3) frame_done)
        else $error("frame_done not at the expected cycle after accept");

    done_low_in_reset: assert property (@(posedge clk)
        !rstn |-> !frame_done)
        else $error("frame_done high during reset");

    done_needs_rearm: assert property (@(posedge clk) disable iff (!rstn)
        frame_done |-> armed)
        else $error("second frame_done without head_flag dropping");

endmodule

bind anc_top anc_sva #(
    .TAPS (TAPS)
) i_anc_sva (
    .clk        (clk),
    .rstn       (rstn),
    .head_flag  (head_flag),
    .phase      (phase),
    .frame_done (frame_done)
);

/* tests/anc_tb.sv */
`timescale 1ns/1ps

module anc_tb
    import anc_pkg::*;
();

    localparam int TAPS         = 8;
    localparam int FRAC_BITS    = 16;
    localparam int MU_SHIFT     = 14;
    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = 2 * TAPS + 3;
    // held-flag test counts as five frames
    localparam int NUM_FRAMES   = 106;
    localparam int GAP_CYCLES   = 4;
    localparam int WATCHDOG_NS  = NUM_FRAMES * (FRAME_CYCLES + GAP_CYCLES) * CLK_PERIOD * 2;

    logic       clk;
    logic       rstn;
    logic       head_flag;
    frame_in_t  frame;
    sample_t    dout;
    logic       frame_done;
    int         seed;
    int         err_count;

    // model delay line and weights with channel a at index 0
    sample_t    ref_m [TAPS];
    weight_t    w_m [2][TAPS];

    anc_top #(
        .TAPS      (TAPS),
        .FRAC_BITS (FRAC_BITS),
        .MU_SHIFT  (MU_SHIFT)
    ) i_anc_top (
        .clk        (clk),
        .rstn       (rstn),
        .head_flag  (head_flag),
        .frame      (frame),
        .dout       (dout),
        .frame_done (frame_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        stop_on_failure();
    end

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input logic signed [63:0] got,
                               input logic signed [63:0] expected, input string what);
        if (got !== expected)
        begin
            err_count++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    function automatic sample_t rand_sample(input int limit);
        int v;
        v = $random(seed) % (limit + 1);
        return sample_t'(v);
    endfunction

    function automatic int magnitude(input sample_t v);
        return (v < 0) ? -int'(v) : int'(v);
    endfunction

    task automatic clear_model();
        for (int k = 0; k < TAPS; k++)
        begin
            ref_m[k]   = '0;
            w_m[0][k] = '0;
            w_m[1][k] = '0;
        end
    endtask

    // fir estimate from current weights then primary minus estimate
    function automatic sample_t model_error(input int ch, input sample_t primary);
        logic signed [ACC_W-1:0] sum;
        sample_t                 est;
        sum = '0;
        for (int k = 0; k < TAPS; k++)
            sum = sum + longint'(w_m[ch][k]) * longint'(ref_m[k]);
        est = sample_t'(sum >>> FRAC_BITS);
        return sample_t'(primary - est);
    endfunction

    task automatic adapt_weights(input int ch, input sample_t e);
        longint  corr;
        weight_t step;
        for (int k = 0; k < TAPS; k++)
        begin
            corr = longint'(e) * longint'(ref_m[k]);
            step = weight_t'(corr) >>> MU_SHIFT;
            w_m[ch][k] = w_m[ch][k] + step;
        end
    endtask

    task automatic model_frame(input frame_in_t f, output sample_t expected);
        sample_t err_a;
        sample_t err_b;
        for (int k = TAPS - 1; k > 0; k--)
            ref_m[k] = ref_m[k-1];
        ref_m[0] = f.noise_ref;
        err_a = model_error(0, f.primary_a);
        err_b = model_error(1, f.primary_b);
        adapt_weights(0, err_a);
        adapt_weights(1, err_b);
        expected = sample_t'(err_a + err_b);
    endtask

    // raise head_flag with a frame and return in the frame_done cycle
    task automatic start_and_wait(input frame_in_t f);
        int cycles;
        @(posedge clk);
        #2;
        frame     = f;
        head_flag = 1'b1;
        cycles    = 0;
        while (!frame_done && cycles < 4 * FRAME_CYCLES)
        begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!frame_done)
        begin
            $display("timeout: no frame_done within %0d cycles of head_flag", cycles);
            stop_on_failure();
        end
        check_value(cycles, FRAME_CYCLES, "frame latency in cycles");
    endtask

    task automatic process_frame(input frame_in_t f, input sample_t expected,
                                 input string what);
        start_and_wait(f);
        check_value(dout, expected, what);
        head_flag = 1'b0;
    endtask

    task automatic test_reset();
        rstn = 1'b0;
        clear_model();
        // flag up during reset must not start anything
        head_flag       = 1'b1;
        frame.noise_ref = rand_sample(511);
        repeat (10)
        begin
            @(posedge clk);
            #2;
            check_value(dout, 0, "dout during reset");
            check_value(frame_done, 0, "frame_done during reset");
        end
        head_flag = 1'b0;
        rstn      = 1'b1;
        repeat (3)
        begin
            @(posedge clk);
            #2;
            check_value(dout, 0, "dout after reset");
            check_value(frame_done, 0, "frame_done after reset");
        end
    endtask

    task automatic test_first_frame();
        frame_in_t f;
        sample_t   expected;
        f.primary_a = sample_t'(300);
        f.primary_b = sample_t'(-170);
        f.noise_ref = sample_t'(211);
        model_frame(f, expected);
        // zero weights give a zero estimate
        check_value(expected, sample_t'(300 - 170), "model first frame");
        process_frame(f, sample_t'(f.primary_a + f.primary_b), "first frame dout");
    endtask

    task automatic test_lms_sequence();
        sample_t   history [$];
        frame_in_t f;
        sample_t   expected;
        history = {};
        repeat (4)
            history.push_front(sample_t'(0));
        for (int n = 0; n < 40; n++)
        begin
            history.push_front(rand_sample(255));
            f.noise_ref = history[0];
            f.primary_a = sample_t'(2 * history[1]);
            f.primary_b = sample_t'(-history[3]);
            void'(history.pop_back());
            model_frame(f, expected);
            process_frame(f, expected, "lms sequence dout");
        end
    endtask

    task automatic test_held_flag();
        frame_in_t f;
        sample_t   expected;
        sample_t   held;
        int        done_count;
        f.primary_a = rand_sample(511);
        f.primary_b = rand_sample(511);
        f.noise_ref = rand_sample(511);
        model_frame(f, expected);
        start_and_wait(f);
        check_value(dout, expected, "held flag dout");
        held       = expected;
        done_count = 1;
        // flag up for three frame lengths in total
        repeat (2 * FRAME_CYCLES)
        begin
            @(posedge clk);
            #2;
            if (frame_done)
                done_count++;
            check_value(dout, held, "dout while head_flag held");
        end
        check_value(done_count, 1, "frame_done count with head_flag held");
        head_flag = 1'b0;
        repeat (3)
        begin
            @(posedge clk);
            #2;
            check_value(dout, held, "dout after head_flag drop");
            check_value(frame_done, 0, "frame_done after head_flag drop");
        end
        f.noise_ref = rand_sample(511);
        model_frame(f, expected);
        process_frame(f, expected, "frame after re-arm");
    endtask

    task automatic test_cancellation();
        frame_in_t frames [60];
        sample_t   expected [60];
        int        first_mag;
        int        last_mag;
        // alternating tone with primary_a equal to the reference
        for (int n = 0; n < 60; n++)
        begin
            frames[n].noise_ref = (n % 2 == 0) ? sample_t'(480) : sample_t'(-480);
            frames[n].primary_a = frames[n].noise_ref;
            frames[n].primary_b = '0;
            model_frame(frames[n], expected[n]);
        end
        first_mag = magnitude(expected[0]);
        last_mag  = magnitude(expected[59]);
        check_value(last_mag < first_mag, 1, "model output shrinks over cancellation");
        for (int n = 0; n < 60; n++)
            process_frame(frames[n], expected[n], "cancellation dout");
    endtask

    initial
    begin
        rstn      = 1'b0;
        head_flag = 1'b0;
        frame     = '0;
        seed      = 50772;
        err_count = 0;
        test_reset();
        test_first_frame();
        test_lms_sequence();
        test_held_flag();
        test_cancellation();
        repeat (2) @(posedge clk);
        if (err_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule
